// File: common/scoreboard_defines.svh
`ifndef SCOREBOARD_DEFINES_SVH
`define SCOREBOARD_DEFINES_SVH

// the horizontal geometry is counted in clocks.
`define H_DISPLAY    256
`define H_TOTAL      309
`define H_SYNC_START 279
`define H_SYNC_END   302

// the vertical geometry is counted in lines.
`define V_DISPLAY    240
`define V_TOTAL      262
`define V_SYNC_START 245
`define V_SYNC_END   248

// lives at reset and at the start of each game.
`define LIVES_START  3

`endif

// File: common/scoreboard_pkg.sv
package scoreboard_pkg;

  // one decimal digit of the display.
  typedef logic [3:0] bcd_digit_t;

  // this digit code draws nothing.
  localparam bcd_digit_t DIGIT_BLANK = 4'd15;

  // a horizontal or vertical screen counter.
  typedef logic [8:0] coord_t;

  typedef enum logic [1:0] {
    state_idle = 2'd0,
    state_play = 2'd1,
    state_over = 2'd2
  } game_state_e;

  // pixel colours are packed as {b, g, r}.
  localparam logic [2:0] RGB_WHITE = 3'b111;
  localparam logic [2:0] RGB_GREEN = 3'b010;
  localparam logic [2:0] RGB_RED   = 3'b001;
  localparam logic [2:0] RGB_BLACK = 3'b000;

endpackage

// File: hw/video_timing.sv
`timescale 1ns/10ps

`include "scoreboard_defines.svh"

module video_timing (
  input  logic                   declives,
  input  logic                   reset,
  output logic                   hsync,
  output logic                   vsync,
  output logic                   display_on,
  output scoreboard_pkg::coord_t hpos,
  output scoreboard_pkg::coord_t vpos
);

  scoreboard_pkg::coord_t h_next;
  scoreboard_pkg::coord_t v_next;
  logic                   h_wrap;
  logic                   v_wrap;

  assign h_wrap = (hpos == scoreboard_pkg::coord_t'(`H_TOTAL - 1));
  assign v_wrap = (vpos == scoreboard_pkg::coord_t'(`V_TOTAL - 1));

  always_comb begin
    h_next = h_wrap ? '0 : hpos + 1'b1;
    v_next = vpos;
    if (h_wrap) begin
      v_next = v_wrap ? '0 : vpos + 1'b1;
    end
  end

  // sync and enable are decoded from the next position, so they line up
  // with hpos and vpos in the same cycle.
  always_ff @(posedge declives or posedge reset) begin
    if (reset) begin
      hpos       <= '0;
      vpos       <= '0;
      hsync      <= 1'b0;
      vsync      <= 1'b0;
      display_on <= 1'b0;
    end else begin
      hpos       <= h_next;
      vpos       <= v_next;
      hsync      <= (h_next >= `H_SYNC_START) && (h_next < `H_SYNC_END);
      vsync      <= (v_next >= `V_SYNC_START) && (v_next < `V_SYNC_END);
      display_on <= (h_next < `H_DISPLAY) && (v_next < `V_DISPLAY);
    end
  end

endmodule

// File: hw/game_control.sv
`timescale 1ns/10ps

module game_control (
  input  logic                        declives,
  input  logic                        reset,
  input  logic                        start,
  input  logic                        score_inc,
  input  logic                        lose_life,
  input  scoreboard_pkg::bcd_digit_t  lives,
  output scoreboard_pkg::game_state_e game_state,
  output logic                        new_game,
  output logic                        game_score_inc,
  output logic                        game_lose_life
);

  logic in_play;
  logic life_left;

  assign in_play = (game_state == scoreboard_pkg::state_play);

  // a loss forwarded last cycle has not reached lives yet, so it is
  // taken off here. A pending new game refills lives anyway.
  assign life_left = new_game || (lives > {3'b000, game_lose_life});

  always_ff @(posedge declives or posedge reset) begin
    if (reset) begin
      game_state     <= scoreboard_pkg::state_idle;
      new_game       <= 1'b0;
      game_score_inc <= 1'b0;
      game_lose_life <= 1'b0;
    end else begin
      new_game       <= 1'b0;
      game_score_inc <= score_inc && in_play;
      game_lose_life <= lose_life && in_play && life_left;
      case (game_state)
        scoreboard_pkg::state_idle: begin
          if (start) begin
            new_game   <= 1'b1;
            game_state <= scoreboard_pkg::state_play;
          end
        end
        scoreboard_pkg::state_play: begin
          // lives still shows the old game until new_game has landed.
          if ((lives == 4'd0) && !new_game) begin
            game_state <= scoreboard_pkg::state_over;
          end
        end
        scoreboard_pkg::state_over: begin
          if (start) begin
            game_state <= scoreboard_pkg::state_idle;
          end
        end
        default: game_state <= scoreboard_pkg::state_idle;
      endcase
    end
  end

endmodule

// File: scoreboard/player_stats.sv
`timescale 1ns/10ps

`include "scoreboard_defines.svh"

module player_stats (
  input  logic                       declives,
  input  logic                       reset,
  input  logic                       new_game,
  input  logic                       game_score_inc,
  input  logic                       game_lose_life,
  output scoreboard_pkg::bcd_digit_t score_tens,
  output scoreboard_pkg::bcd_digit_t score_ones,
  output scoreboard_pkg::bcd_digit_t lives
);

  // the two-digit BCD score wraps from 99 back to 00.
  always_ff @(posedge declives or posedge reset) begin
    if (reset) begin
      score_tens <= 4'd0;
      score_ones <= 4'd0;
    end else if (new_game) begin
      score_tens <= 4'd0;
      score_ones <= 4'd0;
    end else if (game_score_inc) begin
      if (score_ones == 4'd9) begin
        score_ones <= 4'd0;
        if (score_tens == 4'd9) begin
          score_tens <= 4'd0;
        end else begin
          score_tens <= score_tens + 1'b1;
        end
      end else begin
        score_ones <= score_ones + 1'b1;
      end
    end
  end

  // the controller never forwards a loss at zero lives.
  always_ff @(posedge declives or posedge reset) begin
    if (reset) begin
      lives <= scoreboard_pkg::bcd_digit_t'(`LIVES_START);
    end else if (new_game) begin
      lives <= scoreboard_pkg::bcd_digit_t'(`LIVES_START);
    end else if (game_lose_life) begin
      lives <= lives - 1'b1;
    end
  end

endmodule

// File: scoreboard/digit_glyphs.sv
`timescale 1ns/10ps

module digit_glyphs (
  input  scoreboard_pkg::bcd_digit_t digit,
  input  logic [2:0]                 row,
  output logic [4:0]                 bits
);

  // each glyph keeps its top row in the upper bits and the leftmost
  // pixel of a row in bit 4 of that row.
  logic [24:0] glyph;

  always_comb begin
    case (digit)
      4'd0:    glyph = {5'b11111, 5'b10001, 5'b10001, 5'b10001, 5'b11111};
      4'd1:    glyph = {5'b01100, 5'b00100, 5'b00100, 5'b00100, 5'b11111};
      4'd2:    glyph = {5'b11111, 5'b00001, 5'b11111, 5'b10000, 5'b11111};
      4'd3:    glyph = {5'b11111, 5'b00001, 5'b11111, 5'b00001, 5'b11111};
      4'd4:    glyph = {5'b10001, 5'b10001, 5'b11111, 5'b00001, 5'b00001};
      4'd5:    glyph = {5'b11111, 5'b10000, 5'b11111, 5'b00001, 5'b11111};
      4'd6:    glyph = {5'b11111, 5'b10000, 5'b11111, 5'b10001, 5'b11111};
      4'd7:    glyph = {5'b11111, 5'b00001, 5'b00001, 5'b00001, 5'b00001};
      4'd8:    glyph = {5'b11111, 5'b10001, 5'b11111, 5'b10001, 5'b11111};
      4'd9:    glyph = {5'b11111, 5'b10001, 5'b11111, 5'b00001, 5'b11111};
      default: glyph = '0;
    endcase
  end

  always_comb begin
    case (row)
      3'd0:    bits = glyph[24:20];
      3'd1:    bits = glyph[19:15];
      3'd2:    bits = glyph[14:10];
      3'd3:    bits = glyph[9:5];
      3'd4:    bits = glyph[4:0];
      default: bits = 5'b00000;
    endcase
  end

endmodule

// File: scoreboard/scoreboard_render.sv
`timescale 1ns/10ps

module scoreboard_render (
  input  scoreboard_pkg::bcd_digit_t  score_tens,
  input  scoreboard_pkg::bcd_digit_t  score_ones,
  input  scoreboard_pkg::bcd_digit_t  lives,
  input  scoreboard_pkg::game_state_e game_state,
  input  scoreboard_pkg::coord_t      hpos,
  input  scoreboard_pkg::coord_t      vpos,
  input  logic                        display_on,
  output logic [2:0]                  rgb
);

  scoreboard_pkg::bcd_digit_t shown_digit;
  logic [4:0]                 glyph_bits;
  logic [2:0]                 pixel_col;
  logic                       pixel_on;
  logic [2:0]                 colour;

  // each 32-pixel column of the screen holds one digit or nothing.
  always_comb begin
    case (hpos[7:5])
      3'd1:    shown_digit = score_tens;
      3'd2:    shown_digit = score_ones;
      3'd6:    shown_digit = lives;
      default: shown_digit = scoreboard_pkg::DIGIT_BLANK;
    endcase
  end

  digit_glyphs u_digit_glyphs (
    .digit (shown_digit),
    .row   (vpos[4:2]),
    .bits  (glyph_bits)
  );

  // glyph pixels sit in the right five of the eight cells
  assign pixel_col = ~hpos[4:2];
  assign pixel_on  = (pixel_col <= 3'd4) ? glyph_bits[pixel_col] : 1'b0;

  always_comb begin
    case (game_state)
      scoreboard_pkg::state_idle: colour = scoreboard_pkg::RGB_WHITE;
      scoreboard_pkg::state_play: colour = scoreboard_pkg::RGB_GREEN;
      scoreboard_pkg::state_over: colour = scoreboard_pkg::RGB_RED;
      default:                    colour = scoreboard_pkg::RGB_BLACK;
    endcase
  end

  assign rgb = (display_on && pixel_on) ? colour : scoreboard_pkg::RGB_BLACK;

endmodule

// File: hw/scoreboard_top.sv
`timescale 1ns/10ps

module scoreboard_top (
  input  logic                        declives,
  input  logic                        reset,
  input  logic                        start,
  input  logic                        score_inc,
  input  logic                        lose_life,
  output logic                        hsync,
  output logic                        vsync,
  output logic [2:0]                  rgb,
  output scoreboard_pkg::bcd_digit_t  score_tens,
  output scoreboard_pkg::bcd_digit_t  score_ones,
  output scoreboard_pkg::bcd_digit_t  lives,
  output scoreboard_pkg::game_state_e game_state
);

  scoreboard_pkg::coord_t hpos;
  scoreboard_pkg::coord_t vpos;
  logic                   display_on;
  logic                   new_game;
  logic                   game_score_inc;
  logic                   game_lose_life;

  video_timing u_video_timing (
    .declives   (declives),
    .reset      (reset),
    .hsync      (hsync),
    .vsync      (vsync),
    .display_on (display_on),
    .hpos       (hpos),
    .vpos       (vpos)
  );

  game_control u_game_control (
    .declives       (declives),
    .reset          (reset),
    .start          (start),
    .score_inc      (score_inc),
    .lose_life      (lose_life),
    .lives          (lives),
    .game_state     (game_state),
    .new_game       (new_game),
    .game_score_inc (game_score_inc),
    .game_lose_life (game_lose_life)
  );

  player_stats u_player_stats (
    .declives       (declives),
    .reset          (reset),
    .new_game       (new_game),
    .game_score_inc (game_score_inc),
    .game_lose_life (game_lose_life),
    .score_tens     (score_tens),
    .score_ones     (score_ones),
    .lives          (lives)
  );

  scoreboard_render u_scoreboard_render (
    .score_tens (score_tens),
    .score_ones (score_ones),
    .lives      (lives),
    .game_state (game_state),
    .hpos       (hpos),
    .vpos       (vpos),
    .display_on (display_on),
    .rgb        (rgb)
  );

endmodule

// File: test/scoreboard_checker.sv
`timescale 1ns/10ps

`include "scoreboard_defines.svh"

module scoreboard_checker (
  input  logic                        declives,
  input  logic                        reset,
  input  logic                        hsync,
  input  logic                        vsync,
  input  logic [2:0]                  rgb,
  input  scoreboard_pkg::bcd_digit_t  score_tens,
  input  scoreboard_pkg::bcd_digit_t  score_ones,
  input  scoreboard_pkg::bcd_digit_t  lives,
  input  scoreboard_pkg::game_state_e game_state,
  input  logic                        check_valid,
  input  int                          vector_index,
  input  scoreboard_pkg::bcd_digit_t  exp_tens,
  input  scoreboard_pkg::bcd_digit_t  exp_ones,
  input  scoreboard_pkg::bcd_digit_t  exp_lives,
  input  scoreboard_pkg::game_state_e exp_state,
  output logic                        video_done,
  output int                          tests_run,
  output int                          tests_failed
);

  localparam int FRAME = `H_TOTAL * `V_TOTAL;

  int blank_errors = 0;
  int colour_errors = 0;
  int lit_pixels = 0;

  task automatic report_test(input string name, input bit bad);
    tests_run++;
    if (bad) begin
      tests_failed++;
    end
    $display("%s: %s", name, bad ? "fail" : "pass");
  endtask

  task automatic compare_field(input string name, input logic [3:0] expected,
                               input logic [3:0] actual, inout bit bad);
    if (actual !== expected) begin
      $display("[FAIL] %s expected 0x%h got 0x%h", name, expected, actual);
      bad = 1'b1;
    end
  endtask

  // a lit pixel is white in idle, green in play and red in over.
  function automatic logic [2:0] lit_colour(input scoreboard_pkg::game_state_e state);
    case (state)
      scoreboard_pkg::state_play: return scoreboard_pkg::RGB_GREEN;
      scoreboard_pkg::state_over: return scoreboard_pkg::RGB_RED;
      default:                    return scoreboard_pkg::RGB_WHITE;
    endcase
  endfunction

  // counts clocks until the chosen sync line moves to the given level.
  task automatic count_until_edge(input bit use_vsync, input bit level, input int limit,
                                  output int cycles, output bit found);
    logic last;
    logic now_val;
    last   = use_vsync ? vsync : hsync;
    cycles = 0;
    found  = 1'b0;
    while (!found && cycles < limit) begin
      @(negedge declives);
      cycles++;
      now_val = use_vsync ? vsync : hsync;
      found   = (now_val === level) && (last !== level);
      last    = now_val;
    end
  endtask

  // outputs change on the rising edge, so they are sampled on the falling one.
  always @(negedge declives) begin
    bit bad;
    bad = 1'b0;
    if (!reset && check_valid) begin
      compare_field("score_tens", exp_tens, score_tens, bad);
      compare_field("score_ones", exp_ones, score_ones, bad);
      compare_field("lives", exp_lives, lives, bad);
      compare_field("game_state", {2'b00, exp_state}, {2'b00, game_state}, bad);
      report_test($sformatf("vector %0d", vector_index), bad);
    end
    if (!reset && (hsync || vsync) && (rgb !== 3'b000)) begin
      if (blank_errors == 0) begin
        $display("[FAIL] rgb expected 0x0 got 0x%h during sync", rgb);
      end
      blank_errors++;
    end
    if (!reset && (rgb !== 3'b000)) begin
      lit_pixels++;
      if (rgb !== lit_colour(game_state)) begin
        if (colour_errors == 0) begin
          $display("[FAIL] rgb expected 0x%h got 0x%h", lit_colour(game_state), rgb);
        end
        colour_errors++;
      end
    end
  end

  initial begin
    int cycles;
    int width;
    int gap;
    bit found;
    bit bad;
    video_done   = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    @(negedge declives);
    report_test("sync and rgb low in reset",
                (hsync !== 1'b0) || (vsync !== 1'b0) || (rgb !== 3'b000));
    cycles = 0;
    while (reset && cycles < 100) begin
      @(negedge declives);
      cycles++;
    end
    if (reset) begin
      $display("reset stayed high for 100 cycles");
      tests_failed++;
    end
    // the first rise only lines up the count.
    count_until_edge(1'b0, 1'b1, 2 * `H_TOTAL, cycles, found);
    bad = 1'b0;
    for (int n = 0; n < 3 && found; n++) begin
      count_until_edge(1'b0, 1'b1, 2 * `H_TOTAL, cycles, found);
      if (found && cycles != `H_TOTAL) begin
        $display("[FAIL] hsync period expected 0x%h got 0x%h", `H_TOTAL, cycles);
        bad = 1'b1;
      end
    end
    if (!found) begin
      $display("hsync did not rise within two lines");
      bad = 1'b1;
    end
    report_test("hsync period", bad);
    count_until_edge(1'b1, 1'b1, 2 * FRAME, cycles, found);
    if (found) begin
      count_until_edge(1'b1, 1'b0, 2 * FRAME, width, found);
    end
    if (found) begin
      count_until_edge(1'b1, 1'b1, 2 * FRAME, gap, found);
    end
    bad = !found;
    if (!found) begin
      $display("vsync did not toggle within two frames");
    end else begin
      if (width != 3 * `H_TOTAL) begin
        $display("[FAIL] vsync width expected 0x%h got 0x%h", 3 * `H_TOTAL, width);
        bad = 1'b1;
      end
      if (width + gap != FRAME) begin
        $display("[FAIL] vsync period expected 0x%h got 0x%h", FRAME, width + gap);
        bad = 1'b1;
      end
    end
    report_test("vsync timing", bad);
    report_test("rgb blank in sync", blank_errors != 0);
    if (lit_pixels == 0) begin
      $display("no lit pixel was drawn during the video checks");
    end
    report_test("rgb colour", (lit_pixels == 0) || (colour_errors != 0));
    video_done = 1'b1;
  end

endmodule

// File: test/scoreboard_tb.sv
`timescale 1ns/10ps

`include "scoreboard_defines.svh"

module scoreboard_tb;

  localparam int MAX_VECTORS = 32;

  logic                        declives;
  logic                        reset;
  logic                        start;
  logic                        score_inc;
  logic                        lose_life;
  logic                        hsync;
  logic                        vsync;
  logic [2:0]                  rgb;
  scoreboard_pkg::bcd_digit_t  score_tens;
  scoreboard_pkg::bcd_digit_t  score_ones;
  scoreboard_pkg::bcd_digit_t  lives;
  scoreboard_pkg::game_state_e game_state;
  logic                        check_valid;
  int                          vector_index;
  scoreboard_pkg::bcd_digit_t  exp_tens;
  scoreboard_pkg::bcd_digit_t  exp_ones;
  scoreboard_pkg::bcd_digit_t  exp_lives;
  scoreboard_pkg::game_state_e exp_state;
  logic                        video_done;
  int                          tests_run;
  int                          tests_failed;

  // each word holds one vector as {command, count, tens, ones, lives, state}.
  logic [27:0] vectors [MAX_VECTORS];

  always #5 declives = ~declives;

  scoreboard_top u_scoreboard_top (.*);

  scoreboard_checker u_scoreboard_checker (.*);

  function automatic scoreboard_pkg::game_state_e state_from_code(input logic [3:0] code);
    case (code)
      4'd1:    return scoreboard_pkg::state_play;
      4'd2:    return scoreboard_pkg::state_over;
      default: return scoreboard_pkg::state_idle;
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge declives);
    #1;
  endtask

  task automatic apply_command(input logic [3:0] cmd, input logic [7:0] count);
    for (int n = 0; n < count; n++) begin
      start     = (cmd == 4'h1);
      score_inc = (cmd == 4'h2);
      lose_life = (cmd == 4'h3);
      next_cycle();
    end
    start     = 1'b0;
    score_inc = 1'b0;
    lose_life = 1'b0;
    // two edges reach the counters, and leaving play takes one more.
    for (int n = 0; n < 3; n++) begin
      next_cycle();
    end
  endtask

  initial begin
    logic [27:0] word;
    int          waited;
    int          applied;
    bit          broken;
    declives     = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    score_inc    = 1'b0;
    lose_life    = 1'b0;
    check_valid  = 1'b0;
    vector_index = 0;
    exp_tens     = '0;
    exp_ones     = '0;
    exp_lives    = '0;
    exp_state    = scoreboard_pkg::state_idle;
    applied      = 0;
    broken       = 1'b0;
    $readmemh("test/scoreboard_vectors.txt", vectors);
    repeat (5) @(posedge declives);
    #1;
    reset = 1'b0;
    for (int i = 0; i < MAX_VECTORS; i++) begin
      word = vectors[i];
      if ($isunknown(word) || word[27:24] == 4'hf) begin
        break;
      end
      apply_command(word[27:24], word[23:16]);
      vector_index = i;
      exp_tens     = word[15:12];
      exp_ones     = word[11:8];
      exp_lives    = word[7:4];
      exp_state    = state_from_code(word[3:0]);
      check_valid  = 1'b1;
      next_cycle();
      check_valid  = 1'b0;
      applied++;
    end
    if (applied == 0) begin
      $display("no vectors were read from the vectors file");
      broken = 1'b1;
    end
    waited = 0;
    while (!video_done && waited < 3 * `H_TOTAL * `V_TOTAL) begin
      next_cycle();
      waited++;
    end
    if (!video_done) begin
      $display("video timing checks did not finish within three frames");
      broken = 1'b1;
    end
    $display("tests run %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (!broken && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: test/scoreboard_vectors.txt
// command (0 idle, 1 start, 2 inc, 3 lose, f end) _ repeat count _ tens _ ones _ lives
// _ state (0 idle, 1 play, 2 over), expected once the command has settled.
0_01_0_0_3_0
2_02_0_0_3_0
1_01_0_0_3_1
2_01_0_1_3_1
2_0a_1_1_3_1
2_58_9_9_3_1
2_01_0_0_3_1
2_05_0_5_3_1
3_01_0_5_2_1
3_01_0_5_1_1
3_01_0_5_0_2
3_02_0_5_0_2
2_03_0_5_0_2
1_01_0_5_0_0
2_01_0_5_0_0
1_01_0_0_3_1
2_01_0_1_3_1
3_01_0_1_2_1
f_00_0_0_0_0

// File: scoreboard_top.f
+incdir+common
common/scoreboard_pkg.sv
hw/video_timing.sv
hw/game_control.sv
scoreboard/player_stats.sv
scoreboard/digit_glyphs.sv
scoreboard/scoreboard_render.sv
hw/scoreboard_top.sv
test/scoreboard_checker.sv
test/scoreboard_tb.sv

// File: Bender.yml
package:
  name: scoreboard

export_include_dirs:
  - common

sources:
  - common/scoreboard_pkg.sv
  - hw/video_timing.sv
  - hw/game_control.sv
  - scoreboard/player_stats.sv
  - scoreboard/digit_glyphs.sv
  - scoreboard/scoreboard_render.sv
  - hw/scoreboard_top.sv
  - target: test
    files:
      - test/scoreboard_checker.sv
      - test/scoreboard_tb.sv
